// File: rtl/axi_pkg.sv
package axi_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  // single-beat write path, master to slave
  typedef struct packed {
    logic [addr_width-1:0] awaddr;
    logic [2:0]            awsize;
    logic                  awvalid;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  bready;
  } axi_w_m2s_t;

  // no bresp, every write completes okay
  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
  } axi_w_s2m_t;

  // read path, master to slave
  typedef struct packed {
    logic [addr_width-1:0] araddr;
    logic [2:0]            arsize;
    logic                  arvalid;
    logic                  rready;
  } axi_r_m2s_t;

  typedef struct packed {
    logic                  arready;
    logic [data_width-1:0] rdata;
    logic                  rvalid;
  } axi_r_s2m_t;

endpackage

// File: rtl/lsu_pkg.sv
package lsu_pkg;

  localparam int scoreboard_index = 4;

  // memory map
  localparam logic [axi_pkg::addr_width-1:0] mmio_limit = 32'h8000_0000;
  localparam int sram_words = 256;  // decodes addr[9:2]
  localparam int mmio_words = 4;    // decodes addr[3:2]

  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  // one operation from the execute stage
  typedef struct packed {
    logic [axi_pkg::addr_width-1:0] addr;
    mem_size_e                      size;
    logic                           sext;  // sign extend on load
    logic                           write;
    logic [axi_pkg::data_width-1:0] wdata;  // unshifted, low lanes
    logic [scoreboard_index-1:0]    idx;
  } mem_req_t;

  typedef struct packed {
    logic [axi_pkg::data_width-1:0] rdata;
    logic [scoreboard_index-1:0]    idx;
    logic                           write;
  } mem_rsp_t;

endpackage

// File: rtl/lsu.sv
`default_nettype none

module lsu (
  input  logic                 clock,
  input  logic                 reset,

  input  logic                 req_valid,
  output logic                 req_ready,
  input  lsu_pkg::mem_req_t    req,
  input  logic                 commit,

  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output lsu_pkg::mem_rsp_t    rsp,

  output axi_pkg::axi_w_m2s_t  w_m2s,
  input  axi_pkg::axi_w_s2m_t  w_s2m,
  output axi_pkg::axi_r_m2s_t  r_m2s,
  input  axi_pkg::axi_r_s2m_t  r_s2m
);

  import axi_pkg::*;
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_commit,
    st_access,
    st_respond
  } lsu_state_e;

  lsu_state_e state;

  mem_req_t              op_q;
  logic [strb_width-1:0] strb_q;
  logic [data_width-1:0] wdata_q;   // already in its byte lanes
  logic [data_width-1:0] load_q;
  logic                  arvalid_q;
  logic                  awvalid_q;
  logic                  wvalid_q;
  logic                  r_fire;
  logic                  b_fire;

  function automatic logic [strb_width-1:0] size_mask(input mem_size_e size);
    unique case (size)
      size_byte: size_mask = 4'b0001;
      size_half: size_mask = 4'b0011;
      default:   size_mask = 4'b1111;
    endcase
  endfunction

  // bring the addressed lanes down to bit 0, then extend
  function automatic logic [data_width-1:0] extract(input logic [data_width-1:0] word,
                                                    input logic [1:0] offset,
                                                    input mem_size_e size,
                                                    input logic sext);
    logic [data_width-1:0] shifted;
    shifted = word >> {offset, 3'b000};
    unique case (size)
      size_byte: extract = {{24{sext & shifted[7]}}, shifted[7:0]};
      size_half: extract = {{16{sext & shifted[15]}}, shifted[15:0]};
      default:   extract = shifted;
    endcase
  endfunction

  assign req_ready = (state == st_idle);
  assign r_fire    = (state == st_access) && r_s2m.rvalid && r_m2s.rready;
  assign b_fire    = (state == st_access) && w_s2m.bvalid && w_m2s.bready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= st_idle;
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      unique case (state)
        st_idle: begin
          if (req_valid) state <= st_wait_commit;
        end
        st_wait_commit: begin
          // commit only matters while an op is held
          if (commit) begin
            state     <= st_access;
            arvalid_q <= !op_q.write;
            awvalid_q <= op_q.write;
            wvalid_q  <= op_q.write;
          end
        end
        st_access: begin
          if (r_s2m.arready) arvalid_q <= 1'b0;
          if (w_s2m.awready) awvalid_q <= 1'b0;
          if (w_s2m.wready) wvalid_q <= 1'b0;
          if (r_fire || b_fire) state <= st_respond;
        end
        st_respond: begin
          if (!rsp_valid) begin
            rsp_valid <= 1'b1;
          end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      op_q    <= req;
      strb_q  <= size_mask(req.size) << req.addr[1:0];
      wdata_q <= req.wdata << {req.addr[1:0], 3'b000};
    end
    if (r_fire) begin
      load_q <= extract(r_s2m.rdata, op_q.addr[1:0], op_q.size, op_q.sext);
    end else if (b_fire) begin
      load_q <= '0;  // stores return zero
    end
  end

  always_comb begin
    w_m2s.awaddr  = op_q.addr;
    w_m2s.awsize  = {1'b0, op_q.size};
    w_m2s.awvalid = awvalid_q;
    w_m2s.wdata   = wdata_q;
    w_m2s.wstrb   = strb_q;
    w_m2s.wvalid  = wvalid_q;
    w_m2s.bready  = (state == st_access) && op_q.write;

    r_m2s.araddr  = op_q.addr;
    r_m2s.arsize  = {1'b0, op_q.size};
    r_m2s.arvalid = arvalid_q;
    r_m2s.rready  = (state == st_access) && !op_q.write;

    rsp.rdata     = load_q;
    rsp.idx       = op_q.idx;
    rsp.write     = op_q.write;
  end

  a_one_channel: assert property (@(posedge clock) disable iff (reset)
    !(r_m2s.arvalid && w_m2s.awvalid));

  // held response must not move under back-pressure
  a_rsp_stable: assert property (@(posedge clock) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

// File: rtl/axi_addr_decode.sv
`default_nettype none

module axi_addr_decode (
  input  logic                 clock,
  input  logic                 reset,

  input  axi_pkg::axi_w_m2s_t  m_w_m2s,
  output axi_pkg::axi_w_s2m_t  m_w_s2m,
  input  axi_pkg::axi_r_m2s_t  m_r_m2s,
  output axi_pkg::axi_r_s2m_t  m_r_s2m,

  output axi_pkg::axi_w_m2s_t  mem_w_m2s,
  input  axi_pkg::axi_w_s2m_t  mem_w_s2m,
  output axi_pkg::axi_r_m2s_t  mem_r_m2s,
  input  axi_pkg::axi_r_s2m_t  mem_r_s2m,

  output axi_pkg::axi_w_m2s_t  io_w_m2s,
  input  axi_pkg::axi_w_s2m_t  io_w_s2m,
  output axi_pkg::axi_r_m2s_t  io_r_m2s,
  input  axi_pkg::axi_r_s2m_t  io_r_s2m
);

  import lsu_pkg::*;

  // route: 1 = mmio, 0 = sram
  logic w_busy, w_route_q, w_sel, w_done;
  logic r_busy, r_route_q, r_sel, r_done;

  assign w_sel  = w_busy ? w_route_q : (m_w_m2s.awaddr < mmio_limit);
  assign r_sel  = r_busy ? r_route_q : (m_r_m2s.araddr < mmio_limit);
  assign w_done = m_w_s2m.bvalid && m_w_m2s.bready;
  assign r_done = m_r_s2m.rvalid && m_r_m2s.rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      w_busy    <= 1'b0;
      w_route_q <= 1'b0;
      r_busy    <= 1'b0;
      r_route_q <= 1'b0;
    end else begin
      if (w_done) begin
        w_busy <= 1'b0;
      end else if (m_w_m2s.awvalid && !w_busy) begin
        w_busy    <= 1'b1;
        w_route_q <= w_sel;
      end
      if (r_done) begin
        r_busy <= 1'b0;
      end else if (m_r_m2s.arvalid && !r_busy) begin
        r_busy    <= 1'b1;
        r_route_q <= r_sel;
      end
    end
  end

  always_comb begin
    mem_w_m2s = m_w_m2s;
    io_w_m2s  = m_w_m2s;
    mem_r_m2s = m_r_m2s;
    io_r_m2s  = m_r_m2s;
    if (w_sel) {mem_w_m2s.awvalid, mem_w_m2s.wvalid, mem_w_m2s.bready} = '0;
    else {io_w_m2s.awvalid, io_w_m2s.wvalid, io_w_m2s.bready} = '0;
    if (r_sel) {mem_r_m2s.arvalid, mem_r_m2s.rready} = '0;
    else {io_r_m2s.arvalid, io_r_m2s.rready} = '0;
    m_w_s2m = w_sel ? io_w_s2m : mem_w_s2m;
    m_r_s2m = r_sel ? io_r_s2m : mem_r_s2m;
  end

  // a held route still matches the address the master keeps up
  a_route_held: assert property (@(posedge clock) disable iff (reset)
    (!w_busy || w_route_q == (m_w_m2s.awaddr < mmio_limit)) &&
    (!r_busy || r_route_q == (m_r_m2s.araddr < mmio_limit)));

endmodule

`default_nettype wire

// File: rtl/axi_sram.sv
`default_nettype none

module axi_sram (
  input  logic                 clock,
  input  logic                 reset,
  input  axi_pkg::axi_w_m2s_t  w_m2s,
  output axi_pkg::axi_w_s2m_t  w_s2m,
  input  axi_pkg::axi_r_m2s_t  r_m2s,
  output axi_pkg::axi_r_s2m_t  r_s2m
);

  import axi_pkg::*;
  import lsu_pkg::*;

  logic [data_width-1:0] mem [sram_words];

  logic                  r_busy;
  logic [data_width-1:0] rdata_q;
  logic                  aw_got, w_got, b_busy;
  logic [addr_width-1:0] awaddr_q, waddr;
  logic [data_width-1:0] wdata_q, wdata;
  logic [strb_width-1:0] wstrb_q, wstrb;
  logic                  aw_fire, w_fire, do_write;

  assign aw_fire  = w_m2s.awvalid && w_s2m.awready;
  assign w_fire   = w_m2s.wvalid && w_s2m.wready;
  assign do_write = (aw_got || aw_fire) && (w_got || w_fire);
  // take whichever half arrived earlier from its latch
  assign waddr    = aw_got ? awaddr_q : w_m2s.awaddr;
  assign wdata    = w_got ? wdata_q : w_m2s.wdata;
  assign wstrb    = w_got ? wstrb_q : w_m2s.wstrb;

  always_comb begin
    w_s2m.awready = !aw_got && !b_busy;
    w_s2m.wready  = !w_got && !b_busy;
    w_s2m.bvalid  = b_busy;
    r_s2m.arready = !r_busy;
    r_s2m.rdata   = rdata_q;
    r_s2m.rvalid  = r_busy;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      r_busy <= 1'b0;
      aw_got <= 1'b0;
      w_got  <= 1'b0;
      b_busy <= 1'b0;
      mem    <= '{default: '0};
    end else begin
      if (r_m2s.arvalid && r_s2m.arready) begin
        r_busy  <= 1'b1;
        rdata_q <= mem[r_m2s.araddr[$clog2(sram_words)+1:2]];
      end else if (r_m2s.rready) begin
        r_busy <= 1'b0;
      end
      if (aw_fire) awaddr_q <= w_m2s.awaddr;
      if (w_fire) begin
        wdata_q <= w_m2s.wdata;
        wstrb_q <= w_m2s.wstrb;
      end
      if (do_write) begin
        for (int i = 0; i < strb_width; i++) begin
          if (wstrb[i]) mem[waddr[$clog2(sram_words)+1:2]][8*i +: 8] <= wdata[8*i +: 8];
        end
        b_busy <= 1'b1;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end else begin
        if (aw_fire) aw_got <= 1'b1;
        if (w_fire) w_got <= 1'b1;
        if (w_m2s.bready) b_busy <= 1'b0;
      end
    end
  end

  a_strb_nonzero: assert property (@(posedge clock) disable iff (reset)
    w_fire |-> w_m2s.wstrb != '0);

endmodule

`default_nettype wire

// File: rtl/mmio_regs.sv
`default_nettype none

module mmio_regs (
  input  logic                 clock,
  input  logic                 reset,
  input  axi_pkg::axi_w_m2s_t  w_m2s,
  output axi_pkg::axi_w_s2m_t  w_s2m,
  input  axi_pkg::axi_r_m2s_t  r_m2s,
  output axi_pkg::axi_r_s2m_t  r_s2m
);

  import axi_pkg::*;
  import lsu_pkg::*;

  logic [data_width-1:0] regs [mmio_words];  // aliased above addr[3:2]

  logic                  r_busy, aw_got, w_got, b_busy;
  logic [data_width-1:0] rdata_q, wdata_q, wdata;
  logic [strb_width-1:0] wstrb_q, wstrb;
  logic [$clog2(mmio_words)-1:0] sel_q, sel;
  logic                  aw_fire, w_fire, do_write;

  assign aw_fire  = w_m2s.awvalid && w_s2m.awready;
  assign w_fire   = w_m2s.wvalid && w_s2m.wready;
  assign do_write = (aw_got || aw_fire) && (w_got || w_fire);
  assign sel      = aw_got ? sel_q : w_m2s.awaddr[$clog2(mmio_words)+1:2];
  assign wdata    = w_got ? wdata_q : w_m2s.wdata;
  assign wstrb    = w_got ? wstrb_q : w_m2s.wstrb;

  always_comb begin
    w_s2m.awready = !aw_got && !b_busy;
    w_s2m.wready  = !w_got && !b_busy;
    w_s2m.bvalid  = b_busy;
    r_s2m.arready = !r_busy;
    r_s2m.rdata   = rdata_q;
    r_s2m.rvalid  = r_busy;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      {r_busy, aw_got, w_got, b_busy} <= '0;
      regs <= '{default: '0};
    end else begin
      if (r_m2s.arvalid && r_s2m.arready) begin
        r_busy  <= 1'b1;
        rdata_q <= regs[r_m2s.araddr[$clog2(mmio_words)+1:2]];
      end else if (r_m2s.rready) begin
        r_busy <= 1'b0;
      end
      if (aw_fire) sel_q <= w_m2s.awaddr[$clog2(mmio_words)+1:2];
      if (w_fire) {wdata_q, wstrb_q} <= {w_m2s.wdata, w_m2s.wstrb};
      if (do_write) begin  // bvalid follows next cycle
        for (int i = 0; i < strb_width; i++) begin
          if (wstrb[i]) regs[sel][8*i +: 8] <= wdata[8*i +: 8];
        end
        {aw_got, w_got, b_busy} <= 3'b001;
      end else begin
        if (aw_fire) aw_got <= 1'b1;
        if (w_fire) w_got <= 1'b1;
        if (w_m2s.bready) b_busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
`default_nettype none

module lsu_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               req_valid,
  output logic               req_ready,
  input  lsu_pkg::mem_req_t  req,
  input  logic               commit,
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output lsu_pkg::mem_rsp_t  rsp
);

  import axi_pkg::*;

  axi_w_m2s_t lsu_w_m2s, mem_w_m2s, io_w_m2s;
  axi_w_s2m_t lsu_w_s2m, mem_w_s2m, io_w_s2m;
  axi_r_m2s_t lsu_r_m2s, mem_r_m2s, io_r_m2s;
  axi_r_s2m_t lsu_r_s2m, mem_r_s2m, io_r_s2m;

  lsu lsu_i (
    .clock, .reset, .req_valid, .req_ready, .req, .commit,
    .rsp_valid, .rsp_ready, .rsp,
    .w_m2s(lsu_w_m2s), .w_s2m(lsu_w_s2m), .r_m2s(lsu_r_m2s), .r_s2m(lsu_r_s2m)
  );

  axi_addr_decode axi_addr_decode_i (
    .clock, .reset,
    .m_w_m2s(lsu_w_m2s), .m_w_s2m(lsu_w_s2m), .m_r_m2s(lsu_r_m2s), .m_r_s2m(lsu_r_s2m),
    .mem_w_m2s, .mem_w_s2m, .mem_r_m2s, .mem_r_s2m,
    .io_w_m2s, .io_w_s2m, .io_r_m2s, .io_r_s2m
  );

  axi_sram axi_sram_i (
    .clock, .reset,
    .w_m2s(mem_w_m2s), .w_s2m(mem_w_s2m), .r_m2s(mem_r_m2s), .r_s2m(mem_r_s2m)
  );

  mmio_regs mmio_regs_i (
    .clock, .reset,
    .w_m2s(io_w_m2s), .w_s2m(io_w_s2m), .r_m2s(io_r_m2s), .r_s2m(io_r_s2m)
  );

endmodule

`default_nettype wire

// File: bench/lsu_tb.sv
module lsu_tb;

  import lsu_pkg::*;

  localparam int num_ops          = 400;
  localparam int reset_cycles     = 16;
  localparam int max_commit_delay = 5;
  localparam int max_stalls       = 5;
  localparam int rsp_latency      = 4;
  localparam int timeout_cycles   = num_ops * (5 + 5 + 4 + 4) + reset_cycles;

  typedef struct packed {
    logic req_ready;
    logic rsp_valid;
  } handshake_t;

  logic     clock;
  logic     reset;
  logic     req_valid;
  logic     req_ready;
  mem_req_t req;
  logic     commit;
  logic     rsp_valid;
  logic     rsp_ready;
  mem_rsp_t rsp;
  int       cycle_count;

  // byte-level images, index already folded to the aliased range
  logic [7:0] sram_model [sram_words*4];
  logic [7:0] mmio_model [mmio_words*4];

  lsu_top lsu_top_i (
    .clock, .reset, .req_valid, .req_ready, .req, .commit,
    .rsp_valid, .rsp_ready, .rsp
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles, a response never arrived", cycle_count);
      $display("Errors found");
      $fatal(1);
    end
  end

  function automatic int byte_count(input mem_size_e size);
    case (size)
      size_byte: byte_count = 1;
      size_half: byte_count = 2;
      default:   byte_count = 4;
    endcase
  endfunction

  function automatic logic [7:0] model_byte(input logic [31:0] addr);
    if (addr < mmio_limit) model_byte = mmio_model[addr[3:0]];
    else model_byte = sram_model[addr[9:0]];
  endfunction

  task automatic store_byte(input logic [31:0] addr, input logic [7:0] data);
    if (addr < mmio_limit) mmio_model[addr[3:0]] = data;
    else sram_model[addr[9:0]] = data;
  endtask

  function automatic logic [31:0] expected_load(input mem_req_t op);
    logic [31:0] value;
    int          nbytes;
    value  = '0;
    nbytes = byte_count(op.size);
    for (int k = 0; k < nbytes; k++) begin
      value[8*k +: 8] = model_byte(op.addr + k);
    end
    if (op.sext && nbytes == 1) value = {{24{value[7]}}, value[7:0]};
    if (op.sext && nbytes == 2) value = {{16{value[15]}}, value[15:0]};
    return value;
  endfunction

  function automatic mem_req_t random_op();
    mem_req_t    op;
    logic [31:0] addr;
    int          word;
    // mostly a few hot words so loads see earlier stores
    word = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 255) : $urandom_range(0, 15);
    addr = $urandom;  // bit 31 picks the region, upper bits alias
    addr[9:2] = word[7:0];
    op.size = mem_size_e'($urandom_range(0, 2));
    if (op.size == size_half) addr[0] = 1'b0;
    if (op.size == size_word) addr[1:0] = 2'b00;
    op.addr  = addr;
    op.sext  = ($urandom_range(0, 1) == 1);
    op.write = ($urandom_range(0, 4) < 2);
    op.wdata = $urandom;
    op.idx   = 4'($urandom);
    return op;
  endfunction

  function automatic handshake_t make_hs(input logic ready, input logic valid);
    handshake_t hs;
    hs.req_ready = ready;
    hs.rsp_valid = valid;
    return hs;
  endfunction

  task automatic check_rsp(input string name, input mem_rsp_t expected,
                           input mem_rsp_t actual);
    if (actual !== expected) begin
      $display("Error: %s expected rdata %h idx %h write %b, actual rdata %h idx %h write %b",
               name, expected.rdata, expected.idx, expected.write,
               actual.rdata, actual.idx, actual.write);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_idle(input string name, input handshake_t expected,
                            input handshake_t actual);
    if (actual !== expected) begin
      $display("Error: %s expected req_ready %b rsp_valid %b, actual req_ready %b rsp_valid %b",
               name, expected.req_ready, expected.rsp_valid,
               actual.req_ready, actual.rsp_valid);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // entered and left 1 time unit after a rising edge
  task automatic run_op(input string name, input mem_req_t op, input int commit_delay);
    mem_rsp_t   expected;
    handshake_t expect_hs;
    int         cycles;
    int         stalls;
    logic       done;
    expected.rdata = op.write ? '0 : expected_load(op);
    expected.idx   = op.idx;
    expected.write = op.write;
    req       = op;
    req_valid = 1'b1;
    commit    = (commit_delay == 0);
    rsp_ready = 1'b0;
    @(negedge clock);
    check_idle({name, " accept"}, make_hs(1'b1, 1'b0), make_hs(req_ready, rsp_valid));
    @(posedge clock);
    #1;
    req_valid = 1'b0;
    done   = 1'b0;
    cycles = 0;
    stalls = 0;
    while (!done) begin
      if (cycles >= commit_delay) commit = 1'b1;
      rsp_ready = !(stalls < max_stalls && $urandom_range(0, 2) == 0);
      @(negedge clock);
      // response due a fixed latency after commit, stays up while stalled
      expect_hs = make_hs(1'b0, cycles >= commit_delay + rsp_latency);
      check_idle(name, expect_hs, make_hs(req_ready, rsp_valid));
      if (rsp_valid) begin
        check_rsp(name, expected, rsp);
        if (rsp_ready) begin
          done = 1'b1;
        end else begin
          stalls++;
        end
      end
      @(posedge clock);
      #1;
      cycles++;
    end
    commit    = 1'b0;
    rsp_ready = 1'b0;
    if (op.write) begin
      for (int k = 0; k < byte_count(op.size); k++) begin
        store_byte(op.addr + k, op.wdata[8*k +: 8]);
      end
    end
  endtask

  initial begin
    mem_req_t op;
    int       delay;
    void'($urandom(32'h9a89_67d3));
    clock       = 1'b0;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    commit      = 1'b0;
    rsp_ready   = 1'b0;
    cycle_count = 0;
    for (int i = 0; i < sram_words * 4; i++) sram_model[i] = 8'h00;
    for (int i = 0; i < mmio_words * 4; i++) mmio_model[i] = 8'h00;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    check_idle("after reset", make_hs(1'b1, 1'b0), make_hs(req_ready, rsp_valid));
    @(posedge clock);
    #1;
    for (int n = 0; n < num_ops; n++) begin
      op    = random_op();
      delay = $urandom_range(0, max_commit_delay);
      run_op($sformatf("op %0d %s", n, op.write ? "store" : "load"), op, delay);
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: build.f
rtl/axi_pkg.sv
rtl/lsu_pkg.sv
rtl/lsu.sv
rtl/axi_addr_decode.sv
rtl/axi_sram.sv
rtl/mmio_regs.sv
rtl/lsu_top.sv
bench/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu_mem_stage

sources:
  - files:
      - rtl/axi_pkg.sv
      - rtl/lsu_pkg.sv
      - rtl/lsu.sv
      - rtl/axi_addr_decode.sv
      - rtl/axi_sram.sv
      - rtl/mmio_regs.sv
      - rtl/lsu_top.sv
  - target: simulation
    files:
      - bench/lsu_tb.sv
